/* verilog/sdm_dump_defines.svh */
`ifndef SDM_DUMP_DEFINES_SVH
`define SDM_DUMP_DEFINES_SVH

// Decimation window in clock cycles.
// Both channels close a window on the same cycle, so two samples are produced
// per window. With an 8-bit sample the full-scale count of 256 saturates to 255.
`define SDM_WINDOW 256

// Sample FIFO depth in record words.
`define SDM_FIFO_DEPTH 8

// UART bit period in clock cycles.
// A record line is six 10-bit characters, 60 bit periods in total.
`define SDM_BIT_CYCLES 4

`endif

/* verilog/sdm_capture_pkg.sv */
package sdm_capture_pkg;

    localparam int NUM_CHAN = 2;
    localparam int LOST_W = 15;                  // Width of the lost-sample count.

    localparam logic SDM_TAG_SAMPLE = 1'b0;
    localparam logic SDM_TAG_OVF = 1'b1;

    typedef logic sdm_chan_t;                    // Channel index.

    // Sample record layout.
    typedef struct packed {
        logic       tag;
        sdm_chan_t  chan;
        logic [5:0] rsvd;                        // Always zero.
        logic [7:0] value;
    } sdm_sample_t;

    // Overflow record layout.
    typedef struct packed {
        logic              tag;
        logic [LOST_W-1:0] lost;
    } sdm_ovf_t;

    // One FIFO word, decoded by its tag bit.
    typedef union packed {
        sdm_sample_t smp;
        sdm_ovf_t    ovf;
    } sdm_record_t;

endpackage

/* verilog/uart_hex_pkg.sv */
package uart_hex_pkg;

    // Serializer state for one character.
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Position of the character within a line.
    typedef logic [2:0] hex_char_idx_t;

    // Four hex digits, then CR, then LF.
    localparam hex_char_idx_t LINE_LAST_IDX = 3'd5;

    localparam logic [7:0] ASCII_CR = 8'h0D;
    localparam logic [7:0] ASCII_LF = 8'h0A;

endpackage

/* verilog/sdm_capture.sv */
`timescale 1ns/100ps
`include "sdm_dump_defines.svh"

module sdm_capture (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_enable,
    input  logic [1:0]                   i_lvds_in,
    input  logic                         i_full,
    output logic [1:0]                   o_comp_fb,
    output logic                         o_wr_en,
    output sdm_capture_pkg::sdm_record_t o_wr_data,
    output logic                         o_overflow
);
    import sdm_capture_pkg::*;

    localparam int WIN_W = $clog2(`SDM_WINDOW);
    localparam int ONES_W = $clog2(`SDM_WINDOW + 1);

    logic [NUM_CHAN-1:0] sync_q1;
    logic [NUM_CHAN-1:0] sync_q2;
    logic [WIN_W-1:0]    win_cnt;
    logic                win_run;
    logic                win_end;
    logic [ONES_W-1:0]   ones_cnt [NUM_CHAN];
    logic [ONES_W-1:0]   ones_sum [NUM_CHAN];
    logic [7:0]          samp_val [NUM_CHAN];
    logic [NUM_CHAN-1:0] pend;
    logic [LOST_W-1:0]   drop_cnt;
    logic                sel_pend;
    sdm_chan_t           sel_chan;

    // Two-flop synchronizer, looped back as comparator feedback.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= i_lvds_in;
            sync_q2 <= sync_q1;
        end
    end

    assign o_comp_fb = sync_q2;

    // A started window always runs to its end.
    assign win_end = win_run && (win_cnt == WIN_W'(`SDM_WINDOW - 1));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            win_run <= 1'b0;
            win_cnt <= '0;
        end else if (win_end) begin
            win_run <= i_enable;                 // Next window only if still enabled.
            win_cnt <= '0;
        end else if (win_run) begin
            win_cnt <= win_cnt + 1'b1;
        end else if (i_enable) begin
            win_run <= 1'b1;
        end
    end

    always_comb begin
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            ones_sum[ch] = ones_cnt[ch] + ONES_W'(sync_q2[ch]);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                ones_cnt[ch] <= '0;
            end
        end else begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                if (win_end) begin
                    ones_cnt[ch] <= '0;
                end else if (win_run) begin
                    ones_cnt[ch] <= ones_sum[ch];
                end
            end
        end
    end

    // Last bit of the window is included, full scale clips to 255.
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            if (win_end) begin
                samp_val[ch] <= (ones_sum[ch] > ONES_W'(255)) ? 8'hFF : ones_sum[ch][7:0];
            end
        end
    end

    assign sel_pend = |pend;
    assign sel_chan = pend[0] ? 1'b0 : 1'b1;     // Channel 0 goes first.

    assign o_wr_en = (sel_pend || (drop_cnt != '0)) && !i_full;
    assign o_overflow = (drop_cnt != '0);

    always_comb begin
        o_wr_data = '0;
        if (sel_pend) begin
            o_wr_data.smp.tag = SDM_TAG_SAMPLE;
            o_wr_data.smp.chan = sel_chan;
            o_wr_data.smp.value = samp_val[sel_chan];
        end else begin
            o_wr_data.ovf.tag = SDM_TAG_OVF;
            o_wr_data.ovf.lost = drop_cnt;
        end
    end

    // A pending sample is either written or dropped on the cycle it is selected.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend <= '0;
            drop_cnt <= '0;
        end else begin
            if (win_end) begin
                pend <= '1;
            end else if (sel_pend) begin
                pend[sel_chan] <= 1'b0;
            end
            if (sel_pend && i_full) begin
                if (drop_cnt != '1) begin
                    drop_cnt <= drop_cnt + 1'b1;
                end
            end else if (!sel_pend && !i_full) begin
                drop_cnt <= '0;                  // Lost count goes out this cycle.
            end
        end
    end

    // Both samples of a closed window are due on the next two cycles.
    a_pend_two_cycles: assert property (@(posedge clk) disable iff (!i_rst_n)
        win_end |=> sel_pend ##1 sel_pend ##1 !sel_pend);

    a_ovf_count_nonzero: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_wr_en && (o_wr_data.ovf.tag == SDM_TAG_OVF)) |-> (o_wr_data.ovf.lost != '0));

endmodule

/* verilog/sample_fifo.sv */
`timescale 1ns/100ps
`include "sdm_dump_defines.svh"

module sample_fifo (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_wr_en,
    input  sdm_capture_pkg::sdm_record_t i_wr_data,
    input  logic                         i_rd_en,
    output sdm_capture_pkg::sdm_record_t o_rd_data,
    output logic                         o_full,
    output logic                         o_empty
);
    import sdm_capture_pkg::*;

    localparam int DEPTH = `SDM_FIFO_DEPTH;
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    sdm_record_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_nxt;
    logic          wr_ok;
    logic          rd_ok;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_ok = i_wr_en && !o_full;
    assign rd_ok = i_rd_en && !o_empty;

    always_comb begin
        count_nxt = count;
        if (wr_ok && !rd_ok) begin
            count_nxt = count + 1'b1;
        end else if (rd_ok && !wr_ok) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            o_full <= 1'b0;
            o_empty <= 1'b1;
        end else begin
            if (wr_ok) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);
            count <= count_nxt;
            o_full <= (count_nxt == CW'(DEPTH));
            o_empty <= (count_nxt == '0);
        end
    end

    // Read data is valid the cycle after the read strobe.
    always_ff @(posedge clk) begin
        if (wr_ok) mem[wr_ptr] <= i_wr_data;
        if (rd_ok) o_rd_data <= mem[rd_ptr];
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr_en |-> !o_full);

    a_no_read_empty: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rd_en |-> !o_empty);

endmodule

/* verilog/hex_dump_tx.sv */
`timescale 1ns/100ps
`include "sdm_dump_defines.svh"

module hex_dump_tx (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_empty,
    input  sdm_capture_pkg::sdm_record_t i_rd_data,
    output logic                         o_rd_en,
    output logic                         o_uart_tx
);
    import sdm_capture_pkg::*;
    import uart_hex_pkg::*;

    localparam int BAUD_W = $clog2(`SDM_BIT_CYCLES + 1);

    tx_state_t         state;
    hex_char_idx_t     char_idx;
    sdm_record_t       rec_q;
    logic [15:0]       rec_word;
    logic              latch_pend;
    logic [BAUD_W-1:0] baud_cnt;
    logic              baud_end;
    logic [2:0]        bit_idx;
    logic [7:0]        shift_q;
    logic [7:0]        char_code;
    logic              tx_bit;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        return (nib < 4'd10) ? (8'h30 + 8'(nib)) : (8'h37 + 8'(nib));
    endfunction

    // Pop only from idle, one strobe per record.
    assign o_rd_en = (state == TX_IDLE) && !latch_pend && !i_empty;

    assign rec_word = rec_q;
    assign baud_end = (baud_cnt == BAUD_W'(`SDM_BIT_CYCLES - 1));

    always_comb begin
        case (char_idx)
            3'd0:    char_code = hex_ascii(rec_word[15:12]);
            3'd1:    char_code = hex_ascii(rec_word[11:8]);
            3'd2:    char_code = hex_ascii(rec_word[7:4]);
            3'd3:    char_code = hex_ascii(rec_word[3:0]);
            3'd4:    char_code = ASCII_CR;
            default: char_code = ASCII_LF;
        endcase
    end

    always_comb begin
        case (state)
            TX_START: tx_bit = 1'b0;
            TX_DATA:  tx_bit = shift_q[0];       // LSB first.
            default:  tx_bit = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (latch_pend) begin
            rec_q <= i_rd_data;
        end
        if ((state == TX_START) && baud_end) begin
            shift_q <= char_code;
        end else if ((state == TX_DATA) && baud_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= TX_IDLE;
            char_idx <= '0;
            latch_pend <= 1'b0;
            baud_cnt <= '0;
            bit_idx <= '0;
            o_uart_tx <= 1'b1;
        end else begin
            latch_pend <= o_rd_en;
            o_uart_tx <= tx_bit;
            if ((state == TX_IDLE) || baud_end) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (latch_pend) begin
                        state <= TX_START;
                        char_idx <= '0;
                    end
                end
                TX_START: begin
                    if (baud_end) begin
                        state <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (baud_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (baud_end) begin
                        if (char_idx == LINE_LAST_IDX) begin
                            state <= TX_IDLE;
                        end else begin
                            char_idx <= char_idx + 1'b1;
                            state <= TX_START;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Sample records from capture carry clean reserved bits.
    a_sample_rsvd_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        (latch_pend && (i_rd_data.smp.tag == SDM_TAG_SAMPLE)) |->
            ((i_rd_data.smp.rsvd == '0) && !$isunknown(i_rd_data.smp.chan)));

endmodule

/* verilog/sdm_dump_top.sv */
`timescale 1ns/100ps

module sdm_dump_top (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_enable,
    input  logic [1:0] i_lvds_in,
    output logic [1:0] o_comp_fb,
    output logic       o_uart_tx,
    output logic       o_overflow
);
    import sdm_capture_pkg::*;

    logic        wr_en;
    sdm_record_t wr_data;
    logic        fifo_full;
    logic        rd_en;
    sdm_record_t rd_data;
    logic        fifo_empty;

    sdm_capture u_capture (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_enable),
        .i_lvds_in  (i_lvds_in),
        .i_full     (fifo_full),
        .o_comp_fb  (o_comp_fb),
        .o_wr_en    (wr_en),
        .o_wr_data  (wr_data),
        .o_overflow (o_overflow)
    );

    sample_fifo u_fifo (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (wr_en),
        .i_wr_data (wr_data),
        .i_rd_en   (rd_en),
        .o_rd_data (rd_data),
        .o_full    (fifo_full),
        .o_empty   (fifo_empty)
    );

    hex_dump_tx u_tx (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_empty   (fifo_empty),
        .i_rd_data (rd_data),
        .o_rd_en   (rd_en),
        .o_uart_tx (o_uart_tx)
    );

endmodule

/* verif/tb_sdm_dump.sv */
`timescale 1ns/100ps
`include "sdm_dump_defines.svh"

module tb_sdm_dump;

    localparam int WATCHDOG_CYCLES = 200000;

    logic       clk;
    logic       i_rst_n;
    logic       i_enable;
    logic [1:0] i_lvds_in;
    logic [1:0] o_comp_fb;
    logic       o_uart_tx;
    logic       o_overflow;

    string pat_name [$];
    int    pat_duty0 [$];
    int    pat_duty1 [$];
    int    pat_exp0 [$];
    int    pat_exp1 [$];
    int    pat_windows [$];

    string      cur_test = "reset";
    int         duty [2];
    int         phase_ofs [2];
    int         exp_val [2];
    bit         skip_first [2];
    int         cyc_cnt = 0;
    int         fb_valid = 0;
    logic [1:0] lvds_d1 = '0;
    logic [1:0] lvds_d2 = '0;
    logic [7:0] line_chars [6];
    bit         saw_ovf_level = 0;
    int         mismatch_count = 0;
    int         fail_count = 0;
    int         sample_records = 0;
    int         ovf_records = 0;
    int         lost_total = 0;
    int         total_windows = 0;

    sdm_dump_top uut (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_enable),
        .i_lvds_in  (i_lvds_in),
        .o_comp_fb  (o_comp_fb),
        .o_uart_tx  (o_uart_tx),
        .o_overflow (o_overflow)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic compare_value(input string what, input int expected, input int actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
            mismatch_count++;
        end
    endtask

    // Returns -1 for anything but '0'..'9' and 'A'..'F'.
    function automatic int hex_digit_value(input logic [7:0] c);
        if ((c >= 8'h30) && (c <= 8'h39)) return int'(c) - 'h30;
        if ((c >= 8'h41) && (c <= 8'h46)) return int'(c) - 'h41 + 10;
        return -1;
    endfunction

    task automatic load_patterns();
        int    fd;
        int    n_items;
        string line;
        string name;
        int    d0;
        int    d1;
        int    e0;
        int    e1;
        int    nw;
        fd = $fopen("verif/sdm_dump_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verif/sdm_dump_patterns.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                n_items = $fgets(line, fd);
                if ((n_items > 0) && (line[0] != "#")) begin
                    n_items = $sscanf(line, "%s %d %d %d %d %d", name, d0, d1, e0, e1, nw);
                    if (n_items == 6) begin
                        pat_name.push_back(name);
                        pat_duty0.push_back(d0);
                        pat_duty1.push_back(d1);
                        pat_exp0.push_back(e0);
                        pat_exp1.push_back(e1);
                        pat_windows.push_back(nw);
                    end else if (n_items > 0) begin
                        $display("ERROR: malformed pattern line: %s", line);
                        fail_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Drives a periodic comparator stream per channel.
    always @(posedge clk) begin
        #2;
        cyc_cnt = cyc_cnt + 1;
        for (int ch = 0; ch < 2; ch++) begin
            i_lvds_in[ch] = (((cyc_cnt + phase_ofs[ch]) % `SDM_WINDOW) < duty[ch]);
        end
    end

    // Feedback is the input two cycles late.
    always @(negedge clk) begin
        if (!i_rst_n) begin
            fb_valid = 0;
        end else begin
            if (fb_valid >= 2) compare_value("comp_fb", int'(lvds_d2), int'(o_comp_fb));
            else fb_valid++;
        end
        lvds_d2 = lvds_d1;
        lvds_d1 = i_lvds_in;
        if (o_overflow) saw_ovf_level = 1'b1;
    end

    task automatic wait_start_bit(input int max_cycles, output bit found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && (n < max_cycles)) begin
            @(negedge clk);
            if (o_uart_tx === 1'b0) found = 1'b1;
            n++;
        end
    endtask

    // Entered half a cycle into the start bit; samples each bit near its middle.
    task automatic receive_char(output logic [7:0] ch);
        @(negedge clk);
        if (o_uart_tx !== 1'b0) begin
            $display("ERROR: %s: start bit shorter than expected", cur_test);
            fail_count++;
        end
        for (int b = 0; b < 8; b++) begin
            repeat (`SDM_BIT_CYCLES) @(negedge clk);
            ch[b] = o_uart_tx;
        end
        repeat (`SDM_BIT_CYCLES) @(negedge clk);
        if (o_uart_tx !== 1'b1) begin
            $display("ERROR: %s: stop bit missing", cur_test);
            fail_count++;
        end
    endtask

    task automatic process_line();
        logic [15:0] word;
        int          digit;
        int          chan;
        word = '0;
        for (int k = 0; k < 4; k++) begin
            digit = hex_digit_value(line_chars[k]);
            if (digit < 0) begin
                $display("ERROR: %s: character 0x%02h is not an upper-case hex digit",
                         cur_test, line_chars[k]);
                fail_count++;
                digit = 0;
            end
            word = {word[11:0], 4'(digit)};
        end
        compare_value("CR after digits", 'h0D, int'(line_chars[4]));
        compare_value("LF at line end", 'h0A, int'(line_chars[5]));
        if (word[15]) begin
            ovf_records++;
            lost_total += int'(word[14:0]);
            compare_value("overflow count nonzero", 1, int'(word[14:0] != 15'd0));
        end else begin
            chan = int'(word[14]);
            sample_records++;
            compare_value("reserved bits", 0, int'(word[13:8]));
            if (skip_first[chan]) begin
                skip_first[chan] = 1'b0;         // Window straddled the duty change.
            end else begin
                compare_value($sformatf("ch%0d sample", chan), exp_val[chan], int'(word[7:0]));
            end
        end
    endtask

    initial begin : uart_decoder
        bit found;
        bit ok;
        forever begin
            wait_start_bit(1000, found);
            if (found) begin
                receive_char(line_chars[0]);
                ok = 1'b1;
                for (int k = 1; (k < 6) && ok; k++) begin
                    wait_start_bit(4 * `SDM_BIT_CYCLES, found);
                    if (found) begin
                        receive_char(line_chars[k]);
                    end else begin
                        $display("ERROR: %s: line ended after %0d characters", cur_test, k);
                        fail_count++;
                        ok = 1'b0;
                    end
                end
                if (ok) process_line();
            end
        end
    end

    task automatic wait_line_idle(input int quiet_cycles, input int max_cycles);
        int n;
        int idle;
        n = 0;
        idle = 0;
        while ((idle <= quiet_cycles) && (n < max_cycles)) begin
            @(negedge clk);
            n++;
            if (o_uart_tx) idle++;
            else idle = 0;
        end
        if (idle <= quiet_cycles) begin
            $display("ERROR: %s: UART line still busy after %0d cycles", cur_test, max_cycles);
            fail_count++;
        end
    endtask

    task automatic run_test(input int idx, input bit first);
        int enabled_cycles;
        cur_test = pat_name[idx];
        @(negedge clk);
        duty[0] = pat_duty0[idx];
        duty[1] = pat_duty1[idx];
        exp_val[0] = pat_exp0[idx];
        exp_val[1] = pat_exp1[idx];
        skip_first[0] = 1'b1;
        skip_first[1] = 1'b1;
        for (int ch = 0; ch < 2; ch++) begin
            phase_ofs[ch] = int'($urandom % `SDM_WINDOW);
        end
        @(posedge clk);
        #2 i_enable = 1'b1;
        // Drop enable mid-window so exactly the listed number of windows start.
        enabled_cycles = pat_windows[idx] * `SDM_WINDOW - `SDM_WINDOW / 2;
        for (int n = 0; n < enabled_cycles; n++) begin
            @(negedge clk);
            if (first && (n < `SDM_WINDOW)) begin
                compare_value("idle uart line", 1, int'(o_uart_tx));
                compare_value("overflow flag", 0, int'(o_overflow));
            end
        end
        @(posedge clk);
        #2 i_enable = 1'b0;
        total_windows += pat_windows[idx];
        wait_line_idle(300, 8000);
    endtask

    initial begin : main_flow
        void'($urandom(12));
        i_rst_n = 1'b0;
        i_enable = 1'b0;
        i_lvds_in = '0;
        for (int ch = 0; ch < 2; ch++) begin
            duty[ch] = 0;
            phase_ofs[ch] = 0;
        end
        load_patterns();
        if (pat_name.size() == 0) begin
            $display("ERROR: no test patterns loaded");
            fail_count++;
        end
        repeat (4) @(posedge clk);
        #2 i_rst_n = 1'b1;
        for (int t = 0; t < pat_name.size(); t++) begin
            run_test(t, t == 0);
        end
        cur_test = "summary";
        compare_value("overflow flag seen", 1, int'(saw_ovf_level));
        if (ovf_records == 0) begin
            $display("ERROR: no overflow record was received");
            fail_count++;
        end
        compare_value("records plus lost samples", 2 * total_windows, sample_records + lost_total);
        $display("Errors: %0d mismatches, %0d other failures (%0d samples, %0d lost)",
                 mismatch_count, fail_count, sample_records, lost_total);
        if ((mismatch_count == 0) && (fail_count == 0)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
        $display("Something failed");
        $finish;
    end

endmodule

/* verif/sdm_dump_patterns.txt */
# Columns: test name, duty ch0, duty ch1, expected sample ch0, expected sample ch1, windows.
# Duty is the number of high cycles per 256-cycle period; full scale 256 reads back as 255.
quarter_half   64   128  64   128  4
low_high       10   200  10   200  4
full_zero      256  0    255  0    4
zero_full      0    256  0    255  4
one_max        1    255  1    255  4
backlog        77   180  77   180  24
mid_mid        128  127  128  127  5
odd_even       33   222  33   222  4
after_backlog  250  5    250  5    6

/* files.f */
+incdir+verilog
verilog/sdm_capture_pkg.sv
verilog/uart_hex_pkg.sv
verilog/sdm_capture.sv
verilog/sample_fifo.sv
verilog/hex_dump_tx.sv
verilog/sdm_dump_top.sv
verif/tb_sdm_dump.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sdm_dump
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Something failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	fi
	@echo "Result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
